/* logic/ros2_link_params.svh */
`ifndef ROS2_LINK_PARAMS_SVH
`define ROS2_LINK_PARAMS_SVH

// width of one byte on the engine streams.
`define ROS2_LINK_BYTE_W 8

// the transmit FIFO sits between the engine and the IP transmit path.
`define ROS2_LINK_TX_FIFO_DEPTH 16

// the receive FIFO sits between the IP receive path and the engine.
`define ROS2_LINK_RX_FIFO_DEPTH 16

`endif

/* logic/ros2_link_pkg.sv */
`default_nettype none

`include "ros2_link_params.svh"

package ros2_link_pkg;

    // owner of the application-data region.
    typedef enum logic [1:0] {
        grant_none = 2'b00,
        grant_ip   = 2'b01,
        grant_cpu  = 2'b10
    } app_grant_t;

    typedef enum logic {
        owner_ip  = 1'b0, // the protocol engine holds the buffer.
        owner_cpu = 1'b1
    } buf_owner_t;

    typedef struct packed {
        logic ip_req;
        logic ip_rel;
        logic cpu_req;
        logic cpu_rel;
    } arb_req_t;

    typedef struct packed {
        logic ip_rel;
        logic cpu_rel;
    } buf_rel_t;

    typedef logic [`ROS2_LINK_BYTE_W-1:0] stream_byte_t;

    // last marks the final byte of a received packet.
    typedef struct packed {
        stream_byte_t data;
        logic         last;
    } rx_beat_t;

endpackage

`default_nettype wire

/* logic/app_data_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module app_data_arbiter (
    input  logic                      clk_int,
    input  logic                      rst_int,
    input  ros2_link_pkg::arb_req_t   req,
    output ros2_link_pkg::app_grant_t grant
);

    // requests are only looked at while nobody holds the region, so a
    // release always leaves at least one cycle of grant_none behind it.
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            grant <= ros2_link_pkg::grant_none;
        end else begin
            case (grant)
                ros2_link_pkg::grant_none: begin
                    if (req.ip_req) begin
                        grant <= ros2_link_pkg::grant_ip; // the engine wins a tie.
                    end else if (req.cpu_req) begin
                        grant <= ros2_link_pkg::grant_cpu;
                    end
                end
                ros2_link_pkg::grant_ip: begin
                    if (req.ip_rel) begin
                        grant <= ros2_link_pkg::grant_none;
                    end
                end
                ros2_link_pkg::grant_cpu: begin
                    if (req.cpu_rel) begin
                        grant <= ros2_link_pkg::grant_none;
                    end
                end
                default: begin
                    grant <= ros2_link_pkg::grant_none;
                end
            endcase
        end
    end

    // the region never passes straight from the engine to the CPU.
    ip_to_cpu_via_none: assert property (
        @(posedge clk_int) disable iff (rst_int)
        (grant == ros2_link_pkg::grant_ip) |=> (grant != ros2_link_pkg::grant_cpu)
    );

endmodule

`default_nettype wire

/* logic/buffer_owner.sv */
`timescale 1ns/1ns
`default_nettype none

module buffer_owner #(
    parameter ros2_link_pkg::buf_owner_t RESET_OWNER = ros2_link_pkg::owner_ip
) (
    input  logic                      clk_int,
    input  logic                      rst_int,
    input  ros2_link_pkg::buf_rel_t   rel,
    output ros2_link_pkg::buf_owner_t owner
);

    logic holder_rel;

    // only the current holder can give the buffer away.
    assign holder_rel = (owner == ros2_link_pkg::owner_ip) ? rel.ip_rel : rel.cpu_rel;

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            owner <= RESET_OWNER;
        end else if (holder_rel) begin
            if (owner == ros2_link_pkg::owner_ip) begin
                owner <= ros2_link_pkg::owner_cpu;
            end else begin
                owner <= ros2_link_pkg::owner_ip;
            end
        end
    end

    // a change of owner must be preceded by a release from the old holder.
    owner_moves_on_release: assert property (
        @(posedge clk_int) disable iff (rst_int)
        (owner != $past(owner)) |-> (($past(owner) == ros2_link_pkg::owner_ip) ?
            $past(rel.ip_rel) : $past(rel.cpu_rel))
    );

endmodule

`default_nettype wire

/* logic/stream_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
    parameter type T     = ros2_link_pkg::stream_byte_t,
    parameter int  DEPTH = 16
) (
    input  logic clk_int,
    input  logic rst_int,
    input  logic wr,
    input  T     din,
    output logic full,
    input  logic rd,
    output T     dout,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // pointers wrap at DEPTH, which need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_wr = wr && !full; // a write while full is dropped.
    assign do_rd = rd && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // first word fall through.
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk_int) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave it as is.
            endcase
        end
    end

    count_in_range: assert property (
        @(posedge clk_int) disable iff (rst_int)
        count <= CNT_W'(DEPTH)
    );

endmodule

`default_nettype wire

/* logic/ros2_link_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ros2_link_params.svh"

module ros2_link_top (
    input  logic                        clk_int,
    input  logic                        rst_int,

    input  ros2_link_pkg::arb_req_t     app_req,
    output ros2_link_pkg::app_grant_t   app_grant,

    input  ros2_link_pkg::buf_rel_t     rxbuf_rel,
    output ros2_link_pkg::buf_owner_t   rxbuf_owner,
    input  ros2_link_pkg::buf_rel_t     txbuf_rel,
    output ros2_link_pkg::buf_owner_t   txbuf_owner,

    input  logic                        tx_wr,
    input  ros2_link_pkg::stream_byte_t tx_din,
    output logic                        tx_full,
    input  logic                        tx_rd,
    output ros2_link_pkg::stream_byte_t tx_dout,
    output logic                        tx_empty,

    input  logic                        rx_wr,
    input  ros2_link_pkg::rx_beat_t     rx_din,
    output logic                        rx_full,
    input  logic                        rx_rd,
    output ros2_link_pkg::rx_beat_t     rx_dout,
    output logic                        rx_empty
);

    // shares the application-data region between the engine and the CPU.
    app_data_arbiter app_arb (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .req     (app_req),
        .grant   (app_grant)
    );

    // the engine fills the receive buffer first.
    buffer_owner #(
        .RESET_OWNER (ros2_link_pkg::owner_ip)
    ) rxbuf_token (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .rel     (rxbuf_rel),
        .owner   (rxbuf_owner)
    );

    // the CPU fills the transmit buffer first.
    buffer_owner #(
        .RESET_OWNER (ros2_link_pkg::owner_cpu)
    ) txbuf_token (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .rel     (txbuf_rel),
        .owner   (txbuf_owner)
    );

    stream_fifo #(
        .T     (ros2_link_pkg::stream_byte_t),
        .DEPTH (`ROS2_LINK_TX_FIFO_DEPTH)
    ) tx_fifo (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .wr      (tx_wr),
        .din     (tx_din),
        .full    (tx_full),
        .rd      (tx_rd),
        .dout    (tx_dout),
        .empty   (tx_empty)
    );

    // received bytes keep the end-of-packet flag of the IP payload stream.
    stream_fifo #(
        .T     (ros2_link_pkg::rx_beat_t),
        .DEPTH (`ROS2_LINK_RX_FIFO_DEPTH)
    ) rx_fifo (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .wr      (rx_wr),
        .din     (rx_din),
        .full    (rx_full),
        .rd      (rx_rd),
        .dout    (rx_dout),
        .empty   (rx_empty)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_int,
    output logic rst_int
);

    logic [1:0] reset_edges = 2'd0;
    logic       rst_q       = 1'b1;

    assign rst_int = rst_q;

    initial begin
        clk_int = 1'b0;
        forever #4 clk_int = ~clk_int; // 8 ns period.
    end

    // reset is seen by the DUT on the first two rising edges.
    always @(posedge clk_int) begin
        if (reset_edges != 2'd2) begin
            reset_edges <= reset_edges + 2'd1;
        end
        rst_q <= (reset_edges == 2'd0);
    end

endmodule

`default_nettype wire

/* verif/ros2_link_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ros2_link_params.svh"

module ros2_link_tb;

    localparam logic [3:0] OP_STATUS = 4'd0;
    localparam logic [3:0] OP_ARB    = 4'd1;
    localparam logic [3:0] OP_BUF    = 4'd2;
    localparam logic [3:0] OP_TX_WR  = 4'd3;
    localparam logic [3:0] OP_TX_RD  = 4'd4;
    localparam logic [3:0] OP_TX_RW  = 4'd5;
    localparam logic [3:0] OP_RX_WR  = 4'd6;
    localparam logic [3:0] OP_RX_RD  = 4'd7;

    logic                        clk_int;
    logic                        rst_int;
    ros2_link_pkg::arb_req_t     app_req   = '0;
    ros2_link_pkg::app_grant_t   app_grant;
    ros2_link_pkg::buf_rel_t     rxbuf_rel = '0;
    ros2_link_pkg::buf_owner_t   rxbuf_owner;
    ros2_link_pkg::buf_rel_t     txbuf_rel = '0;
    ros2_link_pkg::buf_owner_t   txbuf_owner;
    logic                        tx_wr     = 1'b0;
    ros2_link_pkg::stream_byte_t tx_din    = '0;
    logic                        tx_full;
    logic                        tx_rd     = 1'b0;
    ros2_link_pkg::stream_byte_t tx_dout;
    logic                        tx_empty;
    logic                        rx_wr     = 1'b0;
    ros2_link_pkg::rx_beat_t     rx_din    = '0;
    logic                        rx_full;
    logic                        rx_rd     = 1'b0;
    ros2_link_pkg::rx_beat_t     rx_dout;
    logic                        rx_empty;

    string       row_name [$];
    logic [3:0]  row_op   [$];
    logic [15:0] row_stim [$];
    logic [15:0] row_exp  [$]; // {empty, full} for FIFO rows.

    ros2_link_pkg::stream_byte_t tx_model [$];
    ros2_link_pkg::rx_beat_t     rx_model [$];

    logic [31:0] rng_state = 32'd54319;
    int          checks    = 0;
    int          errors    = 0;
    int          cycles    = 0;

    tb_clock_gen clock_gen (
        .clk_int (clk_int),
        .rst_int (rst_int)
    );

    ros2_link_top UUT (
        .clk_int     (clk_int),
        .rst_int     (rst_int),
        .app_req     (app_req),
        .app_grant   (app_grant),
        .rxbuf_rel   (rxbuf_rel),
        .rxbuf_owner (rxbuf_owner),
        .txbuf_rel   (txbuf_rel),
        .txbuf_owner (txbuf_owner),
        .tx_wr       (tx_wr),
        .tx_din      (tx_din),
        .tx_full     (tx_full),
        .tx_rd       (tx_rd),
        .tx_dout     (tx_dout),
        .tx_empty    (tx_empty),
        .rx_wr       (rx_wr),
        .rx_din      (rx_din),
        .rx_full     (rx_full),
        .rx_rd       (rx_rd),
        .rx_dout     (rx_dout),
        .rx_empty    (rx_empty)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input string name, input logic [3:0] op,
                           input logic [15:0] stim, input logic [15:0] exp_val);
        row_name.push_back(name);
        row_op.push_back(op);
        row_stim.push_back(stim);
        row_exp.push_back(exp_val);
    endtask

    task automatic compare(input string name, input logic [15:0] exp_val,
                           input logic [15:0] act_val);
        checks = checks + 1;
        if (act_val !== exp_val) begin
            errors = errors + 1;
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
        end
    endtask

    task automatic load_table();
        // status bits are {grant, rx owner, tx owner, tx empty, tx full, rx empty, rx full}.
        add_row("reset_status", OP_STATUS, 16'h0000, 16'h001a);
        // arbiter stimulus is {ip_req, ip_rel, cpu_req, cpu_rel}.
        add_row("arb_both_req", OP_ARB, 16'h000a, 16'h0001);
        add_row("arb_cpu_rel_ignored", OP_ARB, 16'h0001, 16'h0001);
        add_row("arb_cpu_req_while_ip", OP_ARB, 16'h0002, 16'h0001);
        add_row("arb_ip_rel_cpu_waiting", OP_ARB, 16'h0006, 16'h0000);
        add_row("arb_cpu_takes_over", OP_ARB, 16'h0002, 16'h0002);
        add_row("arb_ip_req_while_cpu", OP_ARB, 16'h0008, 16'h0002);
        add_row("arb_ip_rel_ignored", OP_ARB, 16'h0004, 16'h0002);
        add_row("arb_cpu_release", OP_ARB, 16'h0001, 16'h0000);
        add_row("arb_idle", OP_ARB, 16'h0000, 16'h0000);
        // token stimulus is {rx ip_rel, rx cpu_rel, tx ip_rel, tx cpu_rel}.
        add_row("buf_nonowner_rel", OP_BUF, 16'h0006, 16'h0001);
        add_row("buf_rx_owner_rel", OP_BUF, 16'h0008, 16'h0003);
        add_row("buf_tx_owner_rel", OP_BUF, 16'h0001, 16'h0002);
        add_row("buf_both_owner_rel", OP_BUF, 16'h0006, 16'h0001);
        add_row("buf_nonowner_again", OP_BUF, 16'h0006, 16'h0001);
        add_row("tx_write_one", OP_TX_WR, 16'h0000, 16'h0000);
        add_row("tx_read_one", OP_TX_RD, 16'h0000, 16'h0002);
        add_row("tx_read_empty", OP_TX_RD, 16'h0000, 16'h0002);
        for (int i = 0; i < 3; i++) begin
            add_row("tx_write", OP_TX_WR, 16'h0000, 16'h0000);
        end
        for (int i = 0; i < 4; i++) begin
            add_row("tx_read_write", OP_TX_RW, 16'h0000, 16'h0000);
        end
        for (int i = 0; i < 3; i++) begin
            add_row("tx_read", OP_TX_RD, 16'h0000, (i == 2) ? 16'h0002 : 16'h0000);
        end
        for (int i = 0; i < 16; i++) begin
            add_row("tx_fill", OP_TX_WR, 16'h0000, (i == 15) ? 16'h0001 : 16'h0000);
        end
        add_row("tx_write_full_drop", OP_TX_WR, 16'h0000, 16'h0001);
        for (int i = 0; i < 16; i++) begin
            add_row("tx_drain", OP_TX_RD, 16'h0000, (i == 15) ? 16'h0002 : 16'h0000);
        end
        for (int i = 0; i < 5; i++) begin
            add_row("rx_write", OP_RX_WR, (i == 2 || i == 4) ? 16'h0001 : 16'h0000, 16'h0000);
        end
        add_row("rx_read", OP_RX_RD, 16'h0000, 16'h0000);
        add_row("rx_read", OP_RX_RD, 16'h0000, 16'h0000);
        add_row("rx_write", OP_RX_WR, 16'h0000, 16'h0000);
        add_row("rx_write", OP_RX_WR, 16'h0001, 16'h0000);
        for (int i = 0; i < 5; i++) begin
            add_row("rx_read", OP_RX_RD, 16'h0000, (i == 4) ? 16'h0002 : 16'h0000);
        end
        add_row("rx_read_empty", OP_RX_RD, 16'h0000, 16'h0002);
        add_row("final_status", OP_STATUS, 16'h0000, 16'h001a);
    endtask

    task automatic apply_row(input int idx);
        string                   name;
        logic [3:0]              op;
        logic [15:0]             stim;
        logic [7:0]              status;
        logic                    tx_accept;
        ros2_link_pkg::rx_beat_t beat;
        name = row_name[idx];
        op   = row_op[idx];
        stim = row_stim[idx];
        // the head entry is stable here, half a cycle after the last edge.
        if ((op == OP_TX_RD || op == OP_TX_RW) && tx_model.size() > 0) begin
            compare(name, {8'h00, tx_model[0]}, {8'h00, tx_dout});
        end
        if (op == OP_RX_RD && rx_model.size() > 0) begin
            compare(name, {7'h00, rx_model[0]}, {7'h00, rx_dout});
        end
        @(posedge clk_int);
        rng_state = xorshift32(rng_state);
        beat.data = rng_state[7:0];
        beat.last = stim[0];
        case (op)
            OP_ARB: app_req <= stim[3:0];
            OP_BUF: begin
                rxbuf_rel <= stim[3:2];
                txbuf_rel <= stim[1:0];
            end
            OP_TX_WR, OP_TX_RW: begin
                tx_wr  <= 1'b1;
                tx_din <= rng_state[7:0];
                tx_rd  <= (op == OP_TX_RW);
                // a full FIFO drops the write, and the read frees no entry in time.
                tx_accept = (tx_model.size() < `ROS2_LINK_TX_FIFO_DEPTH);
                if (op == OP_TX_RW && tx_model.size() > 0) begin
                    void'(tx_model.pop_front());
                end
                if (tx_accept) begin
                    tx_model.push_back(rng_state[7:0]);
                end
            end
            OP_TX_RD: begin
                tx_rd <= 1'b1;
                if (tx_model.size() > 0) begin
                    void'(tx_model.pop_front());
                end
            end
            OP_RX_WR: begin
                rx_wr  <= 1'b1;
                rx_din <= beat;
                if (rx_model.size() < `ROS2_LINK_RX_FIFO_DEPTH) begin
                    rx_model.push_back(beat);
                end
            end
            OP_RX_RD: begin
                rx_rd <= 1'b1;
                if (rx_model.size() > 0) begin
                    void'(rx_model.pop_front());
                end
            end
            default: app_req <= '0;
        endcase
        @(posedge clk_int);
        app_req   <= '0;
        rxbuf_rel <= '0;
        txbuf_rel <= '0;
        tx_wr     <= 1'b0;
        tx_rd     <= 1'b0;
        rx_wr     <= 1'b0;
        rx_rd     <= 1'b0;
        @(negedge clk_int);
        status = {app_grant, rxbuf_owner, txbuf_owner, tx_empty, tx_full, rx_empty, rx_full};
        case (op)
            OP_STATUS: compare(name, row_exp[idx], {8'h00, status});
            OP_ARB: compare(name, row_exp[idx], {14'h0000, app_grant});
            OP_BUF: compare(name, row_exp[idx], {14'h0000, rxbuf_owner, txbuf_owner});
            OP_TX_WR, OP_TX_RD, OP_TX_RW: begin
                compare(name, row_exp[idx], {14'h0000, tx_empty, tx_full});
            end
            default: compare(name, row_exp[idx], {14'h0000, rx_empty, rx_full});
        endcase
    endtask

    initial begin
        load_table();
        @(negedge clk_int);
        while (rst_int) begin
            @(negedge clk_int);
        end
        for (int i = 0; i < row_name.size(); i++) begin
            apply_row(i);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // each row takes about two cycles, so four per row leaves plenty of margin.
    always @(posedge clk_int) begin
        cycles <= cycles + 1;
        if (cycles >= row_name.size() * 4 + 64) begin
            $display("timeout: the table did not finish within %0d cycles", cycles);
            $display("%0d checks, %0d errors", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/ros2_link_pkg.sv
logic/app_data_arbiter.sv
logic/buffer_owner.sv
logic/stream_fifo.sv
logic/ros2_link_top.sv
verif/tb_clock_gen.sv
verif/ros2_link_tb.sv

/* Makefile */
# Verilator build and run for the ROS 2 link fabric testbench.

VERILATOR ?= verilator
TOP       ?= ros2_link_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_MSG  ?= Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
